//--- sim/capture_input_vectors.txt
# name presample downsample max_samples low_res trigger_delay backpressure clip_inject
# backpressure: 0 always ready, 1 random ready, 2 held off until overflow
plain_hr          0  0   32  0   5  0  0
presamp_early    16  0   64  0   6  0  0
presamp_late     16  0   64  0  60  0  0
downsample_only   0  3   40  0   7  0  0
downsample_pre    8  2   40  0  50  0  0
low_res           4  0   33  1  20  0  0
backpressure_hr  10  0  120  0  30  1  0
backpressure_lr   0  1   60  1   9  1  0
clip_inject       0  0   48  0   5  0  1
overflow          0  0  400  0   3  2  0
after_overflow    2  0   20  0  10  0  0

//--- adc_capture.f
common/adc_capture_pkg.sv
capture_ctrl/capture_ctrl_fsm.sv
capture_ctrl/capture_counters.sv
source/presample_fifo.sv
source/sample_packer.sv
source/byte_serializer.sv
source/adc_capture_top.sv
sim/adc_capture_props.sv
sim/tb_adc_capture.sv

//--- Bender.yml
package:
  name: adc_capture

sources:
  - common/adc_capture_pkg.sv
  - capture_ctrl/capture_ctrl_fsm.sv
  - capture_ctrl/capture_counters.sv
  - source/presample_fifo.sv
  - source/sample_packer.sv
  - source/byte_serializer.sv
  - source/adc_capture_top.sv
  - target: simulation
    files:
      - sim/adc_capture_props.sv
      - sim/tb_adc_capture.sv

//--- sim/tb_adc_capture.sv
`timescale 1ns/100ps
`default_nettype none

module tb_adc_capture import adc_capture_pkg::*; ();

    localparam int max_cycles    = 8192;
    localparam int done_timeout  = 6000;
    localparam int flush_timeout = 3000;

    logic                     adc_sampleclk;
    logic                     reset;
    logic [sample_w-1:0]      adc_datain;
    logic                     arm;
    logic                     trigger;
    logic [presample_w-1:0]   presample;
    logic [downsample_w-1:0]  downsample;
    logic [max_samples_w-1:0] max_samples;
    logic                     low_res;
    logic                     byte_ready;
    logic [7:0]               byte_data;
    logic                     byte_valid;
    logic                     capture_done;
    logic [err_w-1:0]         error_stat;

    logic [sample_w-1:0] drawn [max_cycles];    // adc value by cycle after arm
    logic [7:0]          got_bytes [$];
    logic [7:0]          exp_bytes [$];
    logic                exp_clip;
    logic [15:0]         lfsr_state;
    logic                collecting;
    logic                clip_on;
    logic                timed_out;
    int                  bp_mode;    // 0 always ready, 1 random, 2 held off
    int                  n_drawn;
    int                  trig_idx;
    int                  err_cnt;
    int                  tests_run;
    int                  tests_failed;

    adc_capture_top i_dut (
        .adc_sampleclk  (adc_sampleclk),
        .reset          (reset),
        .adc_datain_i   (adc_datain),
        .arm_i          (arm),
        .trigger_i      (trigger),
        .presample_i    (presample),
        .downsample_i   (downsample),
        .max_samples_i  (max_samples),
        .low_res_i      (low_res),
        .byte_ready_i   (byte_ready),
        .byte_data_o    (byte_data),
        .byte_valid_o   (byte_valid),
        .capture_done_o (capture_done),
        .error_stat_o   (error_stat)
    );

    always #5 adc_sampleclk = ~adc_sampleclk;

    // a byte moves at the next rising edge when valid and ready are both high
    always @(negedge adc_sampleclk) begin
        if (collecting && byte_valid && byte_ready)
            got_bytes.push_back(byte_data);
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [sample_w-1:0] draw_sample();
        logic [sample_w-1:0] v;
        for (int i = 0; i < sample_w; i++)
            v[i] = lfsr_bit();
        return v;
    endfunction

    // one clock of stimulus, driven just after the rising edge
    task automatic step_cycle();
        logic [sample_w-1:0] v;
        @(posedge adc_sampleclk);
        #1;
        v = draw_sample();
        if (clip_on && (n_drawn % 16 == 7))
            v = '1;
        else if (clip_on && (n_drawn % 16 == 15))
            v = '0;
        else if (!clip_on && ((v == '0) || (v == '1)))
            v = v ^ 12'h5a5;    // keep clean runs free of clipped values
        arm        = 1'b0;
        adc_datain = v;
        trigger    = (n_drawn == trig_idx);
        if (n_drawn < max_cycles)
            drawn[n_drawn] = v;
        n_drawn++;
        case (bp_mode)
            1:       byte_ready = lfsr_bit();
            2:       byte_ready = 1'b0;
            default: byte_ready = 1'b1;
        endcase
    endtask

    // last pre kept samples before the trigger, then kept samples from the trigger on
    task automatic build_expected(input int pre, input int ds, input int total, input logic lr);
        int                  kept [$];
        logic [sample_w-1:0] a;
        logic [sample_w-1:0] b;
        exp_bytes.delete();
        exp_clip = 1'b0;
        for (int i = 0; i < trig_idx; i++) begin
            if ((pre != 0) && (i % (ds + 1) == 0)) begin
                kept.push_back(i);
                if (kept.size() > pre)
                    void'(kept.pop_front());
            end
        end
        for (int i = trig_idx; (kept.size() < total) && (i < max_cycles); i++) begin
            if ((((pre == 0) ? (i - trig_idx) : i) % (ds + 1)) == 0)
                kept.push_back(i);    // without presamples the divider starts at the trigger
        end
        for (int k = 0; k + 1 < kept.size(); k += 2) begin
            a = drawn[kept[k]];
            b = drawn[kept[k+1]];
            if ((a == '0) || (a == '1) || (b == '0) || (b == '1))
                exp_clip = 1'b1;
            if (lr) begin
                exp_bytes.push_back(a[11:4]);
                exp_bytes.push_back(b[11:4]);
            end else begin
                exp_bytes.push_back(a[11:4]);
                exp_bytes.push_back({a[3:0], b[11:8]});
                exp_bytes.push_back(b[7:0]);
            end
        end
    endtask

    task automatic run_test(input string name, input int pre, input int ds, input int max_s,
                            input int lr, input int td, input int bp, input int clip);
        int               total;
        int               cnt;
        int               quiet;
        int               errs_at_start;
        logic             ds_err;
        logic [err_w-1:0] exp_err;
        total         = max_s & ~1;
        ds_err        = (pre != 0) && (ds != 0);
        errs_at_start = err_cnt;
        tests_run++;
        got_bytes.delete();
        collecting = (bp != 2);
        bp_mode    = bp;
        clip_on    = (clip != 0);
        trig_idx   = td;
        n_drawn    = 0;
        @(posedge adc_sampleclk);
        #1;
        presample   = presample_w'(pre);
        downsample  = downsample_w'(ds);
        max_samples = max_samples_w'(max_s);
        low_res     = (lr != 0);
        trigger     = 1'b0;
        arm         = 1'b1;
        step_cycle();
        if ({capture_done, error_stat} !== {1'b0, ds_err, 2'b00}) begin
            $display("[ERROR] %s: done and status after arm expected %b actual %b",
                     name, {1'b0, ds_err, 2'b00}, {capture_done, error_stat});
            err_cnt++;
        end
        if (bp == 2) begin
            cnt = 0;
            while (!error_stat[0] && (cnt < done_timeout)) begin
                step_cycle();
                cnt++;
            end
            if (!error_stat[0]) begin
                $display("%s: the buffer overflow was never flagged", name);
                err_cnt++;
            end
            bp_mode = 0;    // empty the pipeline before the next arm
            cnt     = 0;
            quiet   = 0;
            while ((quiet < 8) && (cnt < flush_timeout)) begin
                step_cycle();
                quiet = byte_valid ? 0 : quiet + 1;
                cnt++;
            end
            if (quiet < 8) begin
                $display("%s: timed out while draining the byte stream", name);
                timed_out = 1'b1;
                err_cnt++;
            end
        end else begin
            cnt = 0;
            while (!capture_done && (cnt < done_timeout)) begin
                step_cycle();
                cnt++;
            end
            if (!capture_done) begin
                $display("%s: timed out waiting for capture done", name);
                timed_out = 1'b1;
                err_cnt++;
            end else begin
                build_expected(pre, ds, total, lr != 0);
                exp_err = {ds_err, exp_clip, 1'b0};
                if (got_bytes.size() != exp_bytes.size()) begin
                    $display("[ERROR] %s: byte count expected %0d actual %0d",
                             name, exp_bytes.size(), got_bytes.size());
                    err_cnt++;
                end
                for (int i = 0; (i < exp_bytes.size()) && (i < got_bytes.size()); i++) begin
                    if (got_bytes[i] !== exp_bytes[i]) begin
                        $display("[ERROR] %s: byte %0d expected %02h actual %02h",
                                 name, i, exp_bytes[i], got_bytes[i]);
                        err_cnt++;
                        break;
                    end
                end
                if (error_stat !== exp_err) begin
                    $display("[ERROR] %s: error status expected %b actual %b",
                             name, exp_err, error_stat);
                    err_cnt++;
                end
            end
        end
        collecting = 1'b0;
        if (err_cnt == errs_at_start) begin
            $display("%s: ok, %0d bytes", name, got_bytes.size());
        end else begin
            $display("%s: %0d check(s) failed", name, err_cnt - errs_at_start);
            tests_failed++;
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    pre;
        int    ds;
        int    max_s;
        int    lr;
        int    td;
        int    bp;
        int    clip;
        string line;
        string name;
        adc_sampleclk = 1'b0;
        reset         = 1'b1;
        adc_datain    = '0;
        arm           = 1'b0;
        trigger       = 1'b0;
        presample     = '0;
        downsample    = '0;
        max_samples   = '0;
        low_res       = 1'b0;
        byte_ready    = 1'b1;
        lfsr_state    = 16'd2;
        collecting    = 1'b0;
        clip_on       = 1'b0;
        timed_out     = 1'b0;
        bp_mode       = 0;
        n_drawn       = 0;
        trig_idx      = 0;
        err_cnt       = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (2) @(posedge adc_sampleclk);
        #1;
        reset = 1'b0;
        if ((byte_valid !== 1'b0) || (capture_done !== 1'b0)) begin
            $display("[ERROR] reset: byte valid and capture done expected 00 actual %b%b",
                     byte_valid, capture_done);
            err_cnt++;
        end
        fd = $fopen("sim/capture_input_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/capture_input_vectors.txt");
            err_cnt++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                void'($fgets(line, fd));
                if ((line.len() > 1) && (line[0] != "#")) begin
                    n = $sscanf(line, "%s %d %d %d %d %d %d %d",
                                name, pre, ds, max_s, lr, td, bp, clip);
                    if (n == 8)
                        run_test(name, pre, ds, max_s, lr, td, bp, clip);
                end
            end
            $fclose(fd);
        end
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, err_cnt);
        if ((err_cnt == 0) && (tests_run > 0))
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/adc_capture_props.sv
`timescale 1ns/100ps
`default_nettype none

module adc_capture_props import adc_capture_pkg::*; (
    input wire            adc_sampleclk,
    input wire            reset,
    input wire            valid_i,
    input wire            ready_i,
    input wire [7:0]      data_i,
    input wire            done_i,
    input capture_state_t state_i
);

    valid_held: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (valid_i && !ready_i) |=> valid_i)
        else $error("byte valid dropped before ready");

    data_held: assert property (@(posedge adc_sampleclk) disable iff (reset)
        (valid_i && !ready_i) |=> $stable(data_i))
        else $error("byte data changed while waiting for ready");

    // done flag only while finished or back in idle
    done_in_state: assert property (@(posedge adc_sampleclk) disable iff (reset)
        done_i |-> ((state_i == done) || (state_i == idle)))
        else $error("capture done high outside done and idle");

endmodule

bind byte_serializer adc_capture_props i_byte_props (
    .adc_sampleclk (adc_sampleclk),
    .reset         (reset),
    .valid_i       (byte_valid_o),
    .ready_i       (byte_ready_i),
    .data_i        (byte_data_o),
    .done_i        (1'b0),
    .state_i       (adc_capture_pkg::idle)
);

bind capture_ctrl_fsm adc_capture_props i_fsm_props (
    .adc_sampleclk (adc_sampleclk),
    .reset         (reset),
    .valid_i       (1'b0),
    .ready_i       (1'b1),
    .data_i        (8'h00),
    .done_i        (capture_done_o),
    .state_i       (state_o)
);

`default_nettype wire

//--- source/adc_capture_top.sv
`timescale 1ns/100ps
`default_nettype none

module adc_capture_top import adc_capture_pkg::*; (
    input  wire                      adc_sampleclk,
    input  wire                      reset,
    input  wire [sample_w-1:0]       adc_datain_i,
    input  wire                      arm_i,
    input  wire                      trigger_i,
    input  wire [presample_w-1:0]    presample_i,
    input  wire [downsample_w-1:0]   downsample_i,
    input  wire [max_samples_w-1:0]  max_samples_i,
    input  wire                      low_res_i,
    input  wire                      byte_ready_i,
    output logic [7:0]               byte_data_o,
    output logic                     byte_valid_o,
    output logic                     capture_done_o,
    output logic [err_w-1:0]         error_stat_o
);

    capture_state_t      state;
    logic                tick;
    logic                presamp_reached;
    logic                total_reached;
    logic                wr_en;
    logic                drain_en;
    logic                last_tag;
    logic                downsample_err;
    logic                clip_err;
    logic                overflow;
    logic                last_byte_accepted;
    logic [sample_w-1:0] fifo_data;
    logic                fifo_last;
    logic                fifo_valid;
    logic                fifo_ready;
    logic                out_en;
    sample_pair_u        word;
    logic                word_last;
    logic                word_valid;
    logic                word_ready;

    // presamples stay in the buffer until the trigger has been seen
    assign out_en = (state == triggered) || (state == done);

    assign error_stat_o = {downsample_err, clip_err, overflow};

    capture_ctrl_fsm i_fsm (
        .adc_sampleclk        (adc_sampleclk),
        .reset                (reset),
        .arm_i                (arm_i),
        .trigger_i            (trigger_i),
        .presample_i          (presample_i),
        .downsample_i         (downsample_i),
        .tick_i               (tick),
        .presamp_reached_i    (presamp_reached),
        .total_reached_i      (total_reached),
        .last_byte_accepted_i (last_byte_accepted),
        .state_o              (state),
        .wr_en_o              (wr_en),
        .drain_en_o           (drain_en),
        .last_tag_o           (last_tag),
        .downsample_err_o     (downsample_err),
        .capture_done_o       (capture_done_o)
    );

    capture_counters i_counters (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .state_i           (state),
        .wr_en_i           (wr_en),
        .presample_i       (presample_i),
        .downsample_i      (downsample_i),
        .max_samples_i     (max_samples_i),
        .tick_o            (tick),
        .presamp_reached_o (presamp_reached),
        .total_reached_o   (total_reached)
    );

    presample_fifo i_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .sample_i      (adc_datain_i),
        .wr_en_i       (wr_en),
        .drain_en_i    (drain_en),
        .last_i        (last_tag),
        .arm_i         (arm_i),
        .fifo_data_o   (fifo_data),
        .fifo_last_o   (fifo_last),
        .fifo_valid_o  (fifo_valid),
        .overflow_o    (overflow),
        .fifo_ready_i  (fifo_ready && out_en)
    );

    sample_packer i_packer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .fifo_data_i   (fifo_data),
        .fifo_last_i   (fifo_last),
        .fifo_valid_i  (fifo_valid && out_en),
        .arm_i         (arm_i),
        .fifo_ready_o  (fifo_ready),
        .word_o        (word),
        .word_last_o   (word_last),
        .word_valid_o  (word_valid),
        .word_ready_i  (word_ready),
        .clip_err_o    (clip_err)
    );

    byte_serializer i_serializer (
        .adc_sampleclk        (adc_sampleclk),
        .reset                (reset),
        .word_i               (word),
        .word_last_i          (word_last),
        .word_valid_i         (word_valid),
        .low_res_i            (low_res_i),
        .word_ready_o         (word_ready),
        .byte_data_o          (byte_data_o),
        .byte_valid_o         (byte_valid_o),
        .last_byte_accepted_o (last_byte_accepted),
        .byte_ready_i         (byte_ready_i)
    );

endmodule

`default_nettype wire

//--- source/byte_serializer.sv
`timescale 1ns/100ps
`default_nettype none

module byte_serializer import adc_capture_pkg::*; (
    input  wire          adc_sampleclk,
    input  wire          reset,
    input  sample_pair_u word_i,
    input  wire          word_last_i,
    input  wire          word_valid_i,
    input  wire          low_res_i,
    output logic         word_ready_o,
    output logic [7:0]   byte_data_o,
    output logic         byte_valid_o,
    output logic         last_byte_accepted_o,
    input  wire          byte_ready_i
);

    logic [1:0] byte_idx;
    logic       final_byte;
    logic       byte_take;

    // the packer holds its word stable, so bytes are picked straight from it
    assign byte_valid_o = word_valid_i;
    assign byte_take    = byte_valid_o && byte_ready_i;
    assign final_byte   = low_res_i ? (byte_idx == 2'd1) : (byte_idx == 2'd2);

    assign word_ready_o         = byte_take && final_byte;
    assign last_byte_accepted_o = word_ready_o && word_last_i;

    always_comb begin
        if (low_res_i) begin
            // upper 8 bits of each sample, first sample first
            if (byte_idx[0])
                byte_data_o = word_i.samples[0][sample_w-1 -: 8];
            else
                byte_data_o = word_i.samples[1][sample_w-1 -: 8];
        end else begin
            case (byte_idx)
                2'd0:    byte_data_o = word_i.bytes[2];
                2'd1:    byte_data_o = word_i.bytes[1];
                default: byte_data_o = word_i.bytes[0];
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            byte_idx <= 2'd0;
        end else if (byte_take) begin
            if (final_byte)
                byte_idx <= 2'd0;
            else
                byte_idx <= byte_idx + 2'd1;
        end
    end

endmodule

`default_nettype wire

//--- source/sample_packer.sv
`timescale 1ns/100ps
`default_nettype none

module sample_packer import adc_capture_pkg::*; (
    input  wire                 adc_sampleclk,
    input  wire                 reset,
    input  wire [sample_w-1:0]  fifo_data_i,
    input  wire                 fifo_last_i,
    input  wire                 fifo_valid_i,
    input  wire                 arm_i,
    output logic                fifo_ready_o,
    output sample_pair_u        word_o,
    output logic                word_last_o,
    output logic                word_valid_o,
    input  wire                 word_ready_i,
    output logic                clip_err_o
);

    logic [sample_w-1:0] first_q;
    logic                have_first;
    logic                take;
    logic                clipped;

    // the first half of a pair never needs the output slot
    assign fifo_ready_o = !have_first || !word_valid_o || word_ready_i;
    assign take         = fifo_valid_i && fifo_ready_o;
    assign clipped      = (fifo_data_i == '1) || (fifo_data_i == '0);

    always_ff @(posedge adc_sampleclk) begin
        if (take && !have_first)
            first_q <= fifo_data_i;
        if (take && have_first) begin
            word_o.samples <= {first_q, fifo_data_i};
            word_last_o    <= fifo_last_i;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            have_first   <= 1'b0;
            word_valid_o <= 1'b0;
            clip_err_o   <= 1'b0;
        end else if (arm_i) begin
            have_first <= 1'b0;
            clip_err_o <= 1'b0;
        end else begin
            if (take)
                have_first <= !have_first;
            if (take && have_first)
                word_valid_o <= 1'b1;
            else if (word_ready_i)
                word_valid_o <= 1'b0;
            if (take && clipped)
                clip_err_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/presample_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module presample_fifo import adc_capture_pkg::*; (
    input  wire                 adc_sampleclk,
    input  wire                 reset,
    input  wire [sample_w-1:0]  sample_i,
    input  wire                 wr_en_i,
    input  wire                 drain_en_i,
    input  wire                 last_i,
    input  wire                 arm_i,
    output logic [sample_w-1:0] fifo_data_o,
    output logic                fifo_last_o,
    output logic                fifo_valid_o,
    output logic                overflow_o,
    input  wire                 fifo_ready_i
);

    logic [sample_w:0]   mem [buf_depth];    // {last tag, sample}
    logic [buf_addr_w-1:0] wr_ptr;
    logic [buf_addr_w-1:0] rd_ptr;
    logic [buf_addr_w:0]   count;
    logic                  rd_adv;
    logic                  wr_ok;

    assign fifo_valid_o = (count != '0);
    assign {fifo_last_o, fifo_data_o} = mem[rd_ptr];

    // a drain moves the head without presenting it downstream
    assign rd_adv = fifo_valid_o && (fifo_ready_i || drain_en_i);
    assign wr_ok  = wr_en_i && (!count[buf_addr_w] || rd_adv);

    always_ff @(posedge adc_sampleclk) begin
        if (wr_ok)
            mem[wr_ptr] <= {last_i, sample_i};
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (wr_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_adv)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (buf_addr_w+1)'(wr_ok) - (buf_addr_w+1)'(rd_adv);
            if (wr_en_i && !wr_ok)
                overflow_o <= 1'b1;    // sample dropped
        end
    end

endmodule

`default_nettype wire

//--- capture_ctrl/capture_counters.sv
`timescale 1ns/100ps
`default_nettype none

module capture_counters import adc_capture_pkg::*; (
    input  wire                      adc_sampleclk,
    input  wire                      reset,
    input  capture_state_t           state_i,
    input  wire                      wr_en_i,
    input  wire [presample_w-1:0]    presample_i,
    input  wire [downsample_w-1:0]   downsample_i,
    input  wire [max_samples_w-1:0]  max_samples_i,
    output logic                     tick_o,
    output logic                     presamp_reached_o,
    output logic                     total_reached_o
);

    logic [downsample_w-1:0]  ds_cnt;
    logic [presample_w-1:0]   pre_cnt;
    logic [max_samples_w-1:0] tot_cnt;
    logic [max_samples_w-1:0] total_limit;
    logic [max_samples_w-1:0] occupancy;
    logic                     active;

    assign active      = (state_i == presamp_filling) || (state_i == presamp_full) ||
                         (state_i == triggered);
    assign total_limit = {max_samples_i[max_samples_w-1:1], 1'b0};    // even total

    // in presamp_full the buffer holds exactly presample_i entries
    assign occupancy = (state_i == presamp_full) ? max_samples_w'(presample_i) : tot_cnt;

    assign tick_o            = active && (ds_cnt == '0);
    assign presamp_reached_o = (pre_cnt == presample_i - 1'b1);
    assign total_reached_o   = (occupancy == total_limit - 1'b1);

    always_ff @(posedge adc_sampleclk) begin
        if (reset || !active) begin
            ds_cnt  <= '0;
            pre_cnt <= '0;
            tot_cnt <= '0;
        end else begin
            if ((state_i == presamp_full) && (presample_i == '0) && !wr_en_i)
                ds_cnt <= '0;    // no presamples, wait aligned for the trigger
            else if (ds_cnt == downsample_i)
                ds_cnt <= '0;
            else
                ds_cnt <= ds_cnt + 1'b1;

            if ((state_i == presamp_filling) && wr_en_i)
                pre_cnt <= pre_cnt + 1'b1;

            if (state_i == presamp_full)
                tot_cnt <= max_samples_w'(presample_i) + max_samples_w'(wr_en_i);
            else if (wr_en_i)
                tot_cnt <= tot_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- capture_ctrl/capture_ctrl_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module capture_ctrl_fsm import adc_capture_pkg::*; (
    input  wire                     adc_sampleclk,
    input  wire                     reset,
    input  wire                     arm_i,
    input  wire                     trigger_i,
    input  wire [presample_w-1:0]   presample_i,
    input  wire [downsample_w-1:0]  downsample_i,
    input  wire                     tick_i,
    input  wire                     presamp_reached_i,
    input  wire                     total_reached_i,
    input  wire                     last_byte_accepted_i,
    output capture_state_t          state_o,
    output logic                    wr_en_o,
    output logic                    drain_en_o,
    output logic                    last_tag_o,
    output logic                    downsample_err_o,
    output logic                    capture_done_o
);

    capture_state_t next_state;
    capture_state_t start_state;
    logic           capture_end;

    assign start_state = (presample_i != '0) ? presamp_filling : presamp_full;

    always_comb begin
        wr_en_o = 1'b0;
        case (state_o)
            presamp_filling: wr_en_o = tick_i;
            presamp_full:    wr_en_o = tick_i && ((presample_i != '0) || trigger_i);
            triggered:       wr_en_o = tick_i;
            default:         wr_en_o = 1'b0;
        endcase
    end

    // the trigger-edge sample is post-trigger data, so it never drains
    assign drain_en_o = wr_en_o && (state_o == presamp_full) && !trigger_i;

    assign capture_end = wr_en_o && total_reached_i &&
                         ((state_o == triggered) || trigger_i);
    assign last_tag_o  = capture_end;

    always_comb begin
        next_state = state_o;
        if (arm_i) begin
            next_state = start_state;     // arm restarts from anywhere
        end else begin
            case (state_o)
                presamp_filling: begin
                    if (trigger_i)
                        next_state = capture_end ? done : triggered;
                    else if (wr_en_o && presamp_reached_i)
                        next_state = presamp_full;
                end
                presamp_full: begin
                    if (trigger_i)
                        next_state = capture_end ? done : triggered;
                end
                triggered: begin
                    if (capture_end)
                        next_state = done;
                end
                done: begin
                    if (last_byte_accepted_i)
                        next_state = idle;
                end
                default: next_state = idle;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state_o          <= idle;
            downsample_err_o <= 1'b0;
            capture_done_o   <= 1'b0;
        end else begin
            state_o <= next_state;
            if (arm_i) begin
                downsample_err_o <= (downsample_i != '0) && (presample_i != '0);
                capture_done_o   <= 1'b0;
            end else if ((state_o == done) && last_byte_accepted_i) begin
                capture_done_o <= 1'b1;   // stays up until next arm
            end
        end
    end

endmodule

`default_nettype wire

//--- common/adc_capture_pkg.sv
`default_nettype none

package adc_capture_pkg;

    localparam int sample_w      = 12;
    localparam int buf_depth     = 256;
    localparam int buf_addr_w    = 8;
    localparam int presample_w   = 8;
    localparam int downsample_w  = 8;
    localparam int max_samples_w = 16;
    localparam int err_w         = 3;    // [2] downsample, [1] clip, [0] overflow

    typedef enum logic [2:0] {
        idle,
        presamp_filling,
        presamp_full,
        triggered,
        done
    } capture_state_t;

    // samples[1] is the first sample of the pair, bytes[2] goes out first
    typedef union packed {
        logic [1:0][sample_w-1:0] samples;
        logic [2:0][7:0]          bytes;
    } sample_pair_u;

endpackage

`default_nettype wire
